// ==== mem1_pkg.sv ====
`default_nettype none

package mem1_pkg;

    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        LL,
        SB,
        SH,
        SW,
        SWL,
        SWR,
        SC
    } mem_op_t;

    typedef enum logic [4:0] {
        NONE   = 5'd0,
        TLBMOD = 5'd1,
        TLBL   = 5'd2,
        TLBS   = 5'd3,
        ADEL   = 5'd4,
        ADES   = 5'd5
    } exc_code_t;

    localparam logic [2:0] CACHE_CACHEABLE = 3'd3;
    localparam logic [2:0] K0_RESET        = 3'd2;  // uncached

    // top three address bits of the unmapped segments
    localparam logic [2:0] SEG_KSEG0 = 3'd4;
    localparam logic [2:0] SEG_KSEG1 = 3'd5;

    localparam int VPN_W       = 20;
    localparam int PFN_W       = 20;
    localparam int PAGE_OFS_W  = 12;
    localparam int PADDR_LOW_W = 29;

    function automatic logic is_store(mem_op_t op);
        return op inside {SB, SH, SW, SWL, SWR, SC};
    endfunction

endpackage

`default_nettype wire

// ==== mem1_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// lookup of one vpn in the tlb table within the same cycle
interface tlb_lookup_if;
    logic [mem1_pkg::VPN_W-1:0] vpn;
    logic                       found;
    logic                       v;
    logic                       d;
    logic [2:0]                 c;
    logic [mem1_pkg::PFN_W-1:0] pfn;
    logic [2:0]                 k0;

    modport tlb_table (
        input  vpn,
        output found, v, d, c, pfn, k0
    );

    modport client (
        output vpn,
        input  found, v, d, c, pfn, k0
    );
endinterface

// translation result toward the issue stage
interface xlate_if;
    logic [31:0]         paddr;
    logic                uncached;
    logic                tlb_exc;
    logic                refill;
    mem1_pkg::exc_code_t tlb_code;

    modport source (
        output paddr, uncached, tlb_exc, refill, tlb_code
    );

    modport sink (
        input paddr, uncached, tlb_exc, refill, tlb_code
    );
endinterface

`default_nettype wire

// ==== tlb_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_config_regs #(
    parameter int TLB_ENTRIES = 4,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       cfg_tlb_we,
    input  wire logic [IDX_W-1:0]           cfg_index,
    input  wire logic [mem1_pkg::VPN_W-1:0] cfg_vpn,
    input  wire logic [mem1_pkg::PFN_W-1:0] cfg_pfn,
    input  wire logic [2:0]                 cfg_c,
    input  wire logic                       cfg_v,
    input  wire logic                       cfg_d,
    input  wire logic                       cfg_k0_we,
    input  wire logic [2:0]                 cfg_k0,
    tlb_lookup_if.tlb_table                 lk
);

    logic [TLB_ENTRIES-1:0]     ent_present;
    logic [mem1_pkg::VPN_W-1:0] ent_vpn [TLB_ENTRIES];
    logic [mem1_pkg::PFN_W-1:0] ent_pfn [TLB_ENTRIES];
    logic [2:0]                 ent_c   [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]     ent_v;
    logic [TLB_ENTRIES-1:0]     ent_d;
    logic [2:0]                 k0_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_present <= '0;
            k0_q        <= mem1_pkg::K0_RESET;
        end else begin
            if (cfg_tlb_we)
                ent_present[cfg_index] <= 1'b1;
            if (cfg_k0_we)
                k0_q <= cfg_k0;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_tlb_we) begin
            ent_vpn[cfg_index] <= cfg_vpn;
            ent_pfn[cfg_index] <= cfg_pfn;
            ent_c[cfg_index]   <= cfg_c;
            ent_v[cfg_index]   <= cfg_v;
            ent_d[cfg_index]   <= cfg_d;
        end
    end

    // scan from the top so the lowest matching index is left standing
    always_comb begin
        lk.found = 1'b0;
        lk.v     = 1'b0;
        lk.d     = 1'b0;
        lk.c     = 3'd0;
        lk.pfn   = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (ent_present[i] && ent_vpn[i] == lk.vpn) begin
                lk.found = 1'b1;
                lk.v     = ent_v[i];
                lk.d     = ent_d[i];
                lk.c     = ent_c[i];
                lk.pfn   = ent_pfn[i];
            end
        end
    end

    assign lk.k0 = k0_q;

endmodule

`default_nettype wire

// ==== addr_translate.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_translate (
    input  wire logic [31:0]       vaddr,
    input  wire mem1_pkg::mem_op_t op,
    tlb_lookup_if.client           lk,
    xlate_if.source                xl
);

    logic mapped;
    logic kseg0;
    logic kseg1;
    logic store;
    logic miss;
    logic invalid;
    logic modified;

    assign mapped = ~vaddr[31] | (vaddr[31] & vaddr[30]);  // kuseg and kseg2/3
    assign kseg0  = (vaddr[31:29] == mem1_pkg::SEG_KSEG0);
    assign kseg1  = (vaddr[31:29] == mem1_pkg::SEG_KSEG1);
    assign store  = mem1_pkg::is_store(op);

    assign lk.vpn = vaddr[31:mem1_pkg::PAGE_OFS_W];

    assign xl.paddr = mapped ? {lk.pfn, vaddr[mem1_pkg::PAGE_OFS_W-1:0]}
                             : {{(32 - mem1_pkg::PADDR_LOW_W){1'b0}},
                                vaddr[mem1_pkg::PADDR_LOW_W-1:0]};

    assign xl.uncached = kseg1
                       | (kseg0 & (lk.k0 != mem1_pkg::CACHE_CACHEABLE))
                       | (mapped & (lk.c != mem1_pkg::CACHE_CACHEABLE));

    assign miss     = mapped & ~lk.found;
    assign invalid  = mapped & lk.found & ~lk.v;
    assign modified = mapped & lk.found & lk.v & ~lk.d & store;  // clean page written

    assign xl.tlb_exc  = miss | invalid | modified;
    assign xl.refill   = miss;
    assign xl.tlb_code = modified          ? mem1_pkg::TLBMOD :
                         (miss | invalid)  ? (store ? mem1_pkg::TLBS : mem1_pkg::TLBL) :
                                             mem1_pkg::NONE;

endmodule

`default_nettype wire

// ==== access_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_format (
    input  wire mem1_pkg::mem_op_t   op,
    input  wire logic [31:0]         vaddr,
    input  wire logic [31:0]         wdata,
    output logic [3:0]               wstrb,
    output logic [31:0]              wdata_aligned,
    output logic [4:0]               rstrb,
    output logic [1:0]               size,
    output logic                     adr_err,
    output mem1_pkg::exc_code_t      adr_code
);

    logic [1:0] ofs;

    assign ofs = vaddr[1:0];

    always_comb begin
        wstrb         = 4'b0000;  // loads write nothing
        wdata_aligned = wdata;
        case (op)
            mem1_pkg::SB: begin
                wstrb         = 4'b0001 << ofs;
                wdata_aligned = {4{wdata[7:0]}};
            end
            mem1_pkg::SH: begin
                wstrb         = ofs[1] ? 4'b1100 : 4'b0011;
                wdata_aligned = {2{wdata[15:0]}};
            end
            mem1_pkg::SWL: begin
                wstrb         = 4'b1111 >> (2'd3 - ofs);
                wdata_aligned = wdata >> {2'd3 - ofs, 3'b000};
            end
            mem1_pkg::SWR: begin
                wstrb         = 4'b1111 << ofs;
                wdata_aligned = wdata << {ofs, 3'b000};
            end
            mem1_pkg::SW, mem1_pkg::SC: wstrb = 4'b1111;
            default: ;
        endcase
    end

    // read-strobe code for the load aligner downstream
    always_comb begin
        case (op)
            mem1_pkg::LBU: rstrb = {3'b000, ofs};
            mem1_pkg::LB:  rstrb = {3'b010, ofs};
            mem1_pkg::LHU: rstrb = {3'b001, ofs[1], 1'b0};
            mem1_pkg::LH:  rstrb = {3'b011, ofs[1], 1'b0};
            mem1_pkg::LWL: begin
                case (ofs)
                    2'd0:    rstrb = 5'd24;
                    2'd1:    rstrb = 5'd28;
                    2'd2:    rstrb = 5'd30;
                    default: rstrb = 5'd31;
                endcase
            end
            mem1_pkg::LWR: begin
                case (ofs)
                    2'd0:    rstrb = 5'd31;
                    2'd1:    rstrb = 5'd23;
                    2'd2:    rstrb = 5'd19;
                    default: rstrb = 5'd17;
                endcase
            end
            default: rstrb = 5'd31;
        endcase
    end

    always_comb begin
        case (op)
            mem1_pkg::LB, mem1_pkg::LBU, mem1_pkg::SB: size = 2'd0;
            mem1_pkg::LH, mem1_pkg::LHU, mem1_pkg::SH: size = 2'd1;
            default:                                    size = 2'd2;
        endcase
    end

    always_comb begin
        case (op)
            mem1_pkg::LW, mem1_pkg::LL, mem1_pkg::SW, mem1_pkg::SC:
                adr_err = (ofs != 2'd0);
            mem1_pkg::LH, mem1_pkg::LHU, mem1_pkg::SH:
                adr_err = ofs[0];
            default:
                adr_err = 1'b0;  // lwl/lwr/swl/swr take any offset
        endcase
    end

    assign adr_code = !adr_err                  ? mem1_pkg::NONE :
                      mem1_pkg::is_store(op)    ? mem1_pkg::ADES : mem1_pkg::ADEL;

endmodule

`default_nettype wire

// ==== ll_sc_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module ll_sc_link (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              accept,
    input  wire mem1_pkg::mem_op_t op,
    input  wire logic [31:0]       vaddr,
    input  wire logic              exc,
    output logic                   sc_ok
);

    logic        link;
    logic [31:0] link_addr;

    always_ff @(posedge clk) begin
        if (rst)
            link <= 1'b0;
        else if (accept) begin
            if (exc || op == mem1_pkg::SC)
                link <= 1'b0;  // sc always consumes the link
            else if (op == mem1_pkg::LL)
                link <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !exc && op == mem1_pkg::LL)
            link_addr <= vaddr;
    end

    assign sc_ok = (op == mem1_pkg::SC) & link & (link_addr == vaddr);

endmodule

`default_nettype wire

// ==== mem1_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem1_issue (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire mem1_pkg::mem_op_t   in_op,
    input  wire logic [31:0]         in_vaddr,
    output logic                     in_ready,
    xlate_if.sink                    xl,
    input  wire logic [3:0]          wstrb,
    input  wire logic [31:0]         wdata_aligned,
    input  wire logic [4:0]          rstrb,
    input  wire logic [1:0]          size,
    input  wire logic                adr_err,
    input  wire mem1_pkg::exc_code_t adr_code,
    input  wire logic                sc_ok,
    output logic                     exc,
    output logic                     accept,
    input  wire logic                out_ready,
    output logic                     out_valid,
    output logic                     out_exc,
    output mem1_pkg::exc_code_t      out_exc_code,
    output logic                     out_refill,
    output logic [31:0]              out_badvaddr,
    output logic                     out_uncached,
    output logic [31:0]              out_paddr,
    output logic                     out_write,
    output logic [3:0]               out_wstrb,
    output logic [31:0]              out_wdata,
    output logic [4:0]               out_rstrb,
    output logic [1:0]               out_size,
    output logic                     out_sc_ok
);

    logic                is_sc;
    logic                write;
    mem1_pkg::exc_code_t exc_code;

    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    // address error wins over any tlb fault
    assign exc      = adr_err | xl.tlb_exc;
    assign exc_code = adr_err ? adr_code : xl.tlb_code;
    assign is_sc    = (in_op == mem1_pkg::SC);
    assign write    = mem1_pkg::is_store(in_op) & ~exc & (~is_sc | sc_ok);

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_exc      <= exc;
            out_exc_code <= exc_code;
            out_refill   <= ~adr_err & xl.refill;
            out_badvaddr <= exc ? in_vaddr : 32'd0;
            out_uncached <= xl.uncached;
            out_paddr    <= xl.paddr;
            out_write    <= write;
            out_wstrb    <= write ? wstrb : 4'b0000;
            out_wdata    <= wdata_aligned;
            out_rstrb    <= rstrb;
            out_size     <= size;
            out_sc_ok    <= is_sc & write;  // failed sc reports 0
        end
    end

endmodule

`default_nettype wire

// ==== mem1_prep_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem1_prep_top #(
    parameter int TLB_ENTRIES = 4,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire mem1_pkg::mem_op_t          in_op,
    input  wire logic [31:0]                in_vaddr,
    input  wire logic [31:0]                in_wdata,
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output logic                            out_exc,
    output mem1_pkg::exc_code_t             out_exc_code,
    output logic                            out_refill,
    output logic [31:0]                     out_badvaddr,
    output logic                            out_uncached,
    output logic [31:0]                     out_paddr,
    output logic                            out_write,
    output logic [3:0]                      out_wstrb,
    output logic [31:0]                     out_wdata,
    output logic [4:0]                      out_rstrb,
    output logic [1:0]                      out_size,
    output logic                            out_sc_ok,
    input  wire logic                       cfg_tlb_we,
    input  wire logic [IDX_W-1:0]           cfg_index,
    input  wire logic [mem1_pkg::VPN_W-1:0] cfg_vpn,
    input  wire logic [mem1_pkg::PFN_W-1:0] cfg_pfn,
    input  wire logic [2:0]                 cfg_c,
    input  wire logic                       cfg_v,
    input  wire logic                       cfg_d,
    input  wire logic                       cfg_k0_we,
    input  wire logic [2:0]                 cfg_k0
);

    tlb_lookup_if lk_if ();
    xlate_if      xl_if ();

    logic [3:0]          fmt_wstrb;
    logic [31:0]         fmt_wdata;
    logic [4:0]          fmt_rstrb;
    logic [1:0]          fmt_size;
    logic                fmt_adr_err;
    mem1_pkg::exc_code_t fmt_adr_code;
    logic                sc_ok;
    logic                exc;
    logic                accept;

    tlb_config_regs #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_cfg (
        .clk(clk), .rst(rst),
        .cfg_tlb_we(cfg_tlb_we), .cfg_index(cfg_index), .cfg_vpn(cfg_vpn),
        .cfg_pfn(cfg_pfn), .cfg_c(cfg_c), .cfg_v(cfg_v), .cfg_d(cfg_d),
        .cfg_k0_we(cfg_k0_we), .cfg_k0(cfg_k0),
        .lk(lk_if.tlb_table)
    );

    addr_translate u_xlate (
        .vaddr(in_vaddr), .op(in_op), .lk(lk_if.client), .xl(xl_if.source)
    );

    access_format u_fmt (
        .op(in_op), .vaddr(in_vaddr), .wdata(in_wdata),
        .wstrb(fmt_wstrb), .wdata_aligned(fmt_wdata), .rstrb(fmt_rstrb),
        .size(fmt_size), .adr_err(fmt_adr_err), .adr_code(fmt_adr_code)
    );

    ll_sc_link u_link (
        .clk(clk), .rst(rst), .accept(accept), .op(in_op), .vaddr(in_vaddr),
        .exc(exc), .sc_ok(sc_ok)
    );

    mem1_issue u_issue (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_op(in_op), .in_vaddr(in_vaddr), .in_ready(in_ready),
        .xl(xl_if.sink),
        .wstrb(fmt_wstrb), .wdata_aligned(fmt_wdata), .rstrb(fmt_rstrb),
        .size(fmt_size), .adr_err(fmt_adr_err), .adr_code(fmt_adr_code),
        .sc_ok(sc_ok), .exc(exc), .accept(accept),
        .out_ready(out_ready), .out_valid(out_valid),
        .out_exc(out_exc), .out_exc_code(out_exc_code), .out_refill(out_refill),
        .out_badvaddr(out_badvaddr), .out_uncached(out_uncached),
        .out_paddr(out_paddr), .out_write(out_write), .out_wstrb(out_wstrb),
        .out_wdata(out_wdata), .out_rstrb(out_rstrb), .out_size(out_size),
        .out_sc_ok(out_sc_ok)
    );

endmodule

`default_nettype wire

// ==== tb_mem1_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem1_prep;

    localparam int TLB_N = 4;

    typedef struct packed {
        logic        exc;
        logic [4:0]  code;
        logic        refill;
        logic [31:0] badvaddr;
        logic        uncached;
        logic [31:0] paddr;
        logic        write;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [4:0]  rstrb;
        logic [1:0]  size;
        logic        sc_ok;
    } beat_t;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    mem1_pkg::mem_op_t in_op;
    logic [31:0] in_vaddr;
    logic [31:0] in_wdata;
    logic out_valid;
    logic out_ready;
    logic out_exc;
    mem1_pkg::exc_code_t out_exc_code;
    logic out_refill;
    logic [31:0] out_badvaddr;
    logic out_uncached;
    logic [31:0] out_paddr;
    logic out_write;
    logic [3:0] out_wstrb;
    logic [31:0] out_wdata;
    logic [4:0] out_rstrb;
    logic [1:0] out_size;
    logic out_sc_ok;
    logic cfg_tlb_we;
    logic [1:0] cfg_index;
    logic [19:0] cfg_vpn;
    logic [19:0] cfg_pfn;
    logic [2:0] cfg_c;
    logic cfg_v;
    logic cfg_d;
    logic cfg_k0_we;
    logic [2:0] cfg_k0;

    // reference state
    logic        m_present [TLB_N];
    logic [19:0] m_vpn [TLB_N];
    logic [19:0] m_pfn [TLB_N];
    logic [2:0]  m_c [TLB_N];
    logic        m_v [TLB_N];
    logic        m_d [TLB_N];
    logic [2:0]  m_k0;
    logic        m_link;
    logic [31:0] m_link_addr;

    beat_t exp_q[$];
    beat_t act;
    beat_t held;
    logic  held_valid;
    logic  bp_mode;
    int    checks;
    int    errors;
    int    test_no;
    int    checks_at;
    int    errors_at;

    mem1_prep_top #(.TLB_ENTRIES(TLB_N)) u_mem1_prep_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic op_writes_memory(mem1_pkg::mem_op_t op);
        return op inside {mem1_pkg::SB, mem1_pkg::SH, mem1_pkg::SW, mem1_pkg::SWL,
                          mem1_pkg::SWR, mem1_pkg::SC};
    endfunction

    function automatic beat_t expect_beat(mem1_pkg::mem_op_t op, logic [31:0] va,
                                          logic [31:0] wd);
        beat_t      b;
        logic       st;
        logic       mapped;
        logic       hit;
        logic       adr_bad;
        logic       tlb_bad;
        logic [4:0] tcode;
        logic [3:0] strb;
        logic [1:0] o;
        int         idx;
        b       = '0;
        o       = va[1:0];
        st      = op_writes_memory(op);
        mapped  = !va[31] || va[30];
        hit     = 1'b0;
        idx     = 0;
        for (int i = 0; i < TLB_N; i++) begin
            if (!hit && m_present[i] && m_vpn[i] == va[31:12]) begin
                hit = 1'b1;
                idx = i;
            end
        end
        case (op)
            mem1_pkg::LW, mem1_pkg::LL, mem1_pkg::SW, mem1_pkg::SC: adr_bad = (o != 2'd0);
            mem1_pkg::LH, mem1_pkg::LHU, mem1_pkg::SH:              adr_bad = o[0];
            default:                                                adr_bad = 1'b0;
        endcase
        tlb_bad = 1'b0;
        tcode   = 5'd0;
        if (mapped && (!hit || !m_v[idx])) begin
            tlb_bad = 1'b1;
            tcode   = st ? 5'd3 : 5'd2;
        end else if (mapped && st && !m_d[idx]) begin
            tlb_bad = 1'b1;
            tcode   = 5'd1;  // clean page
        end
        b.exc      = adr_bad || tlb_bad;
        b.code     = adr_bad ? (st ? 5'd5 : 5'd4) : tcode;
        b.refill   = !adr_bad && mapped && !hit;
        b.badvaddr = b.exc ? va : 32'd0;
        b.paddr    = mapped ? {m_pfn[idx], va[11:0]} : {3'b000, va[28:0]};
        b.uncached = (va[31:29] == 3'd5) || (va[31:29] == 3'd4 && m_k0 != 3'd3)
                     || (mapped && m_c[idx] != 3'd3);
        b.sc_ok    = (op == mem1_pkg::SC) && m_link && m_link_addr == va;
        b.write    = st && !b.exc && (op != mem1_pkg::SC || b.sc_ok);
        b.sc_ok    = b.sc_ok && b.write;
        strb       = 4'b0000;
        b.wdata    = wd;
        case (op)
            mem1_pkg::SB: begin
                strb    = 4'b0001 << o;
                b.wdata = {4{wd[7:0]}};
            end
            mem1_pkg::SH: begin
                strb    = o[1] ? 4'b1100 : 4'b0011;
                b.wdata = {2{wd[15:0]}};
            end
            mem1_pkg::SWL: begin
                case (o)
                    2'd0:    strb = 4'b0001;
                    2'd1:    strb = 4'b0011;
                    2'd2:    strb = 4'b0111;
                    default: strb = 4'b1111;
                endcase
                b.wdata = wd >> (8 * (3 - int'(o)));
            end
            mem1_pkg::SWR: begin
                case (o)
                    2'd0:    strb = 4'b1111;
                    2'd1:    strb = 4'b1110;
                    2'd2:    strb = 4'b1100;
                    default: strb = 4'b1000;
                endcase
                b.wdata = wd << (8 * int'(o));
            end
            mem1_pkg::SW, mem1_pkg::SC: strb = 4'b1111;
            default: ;
        endcase
        b.wstrb = b.write ? strb : 4'b0000;
        case (op)
            mem1_pkg::LBU: b.rstrb = {3'b000, o};
            mem1_pkg::LB:  b.rstrb = 5'd8 + {3'b000, o};
            mem1_pkg::LHU: b.rstrb = o[1] ? 5'd6 : 5'd4;
            mem1_pkg::LH:  b.rstrb = o[1] ? 5'd14 : 5'd12;
            mem1_pkg::LWL: b.rstrb = (o == 0) ? 5'd24 : (o == 1) ? 5'd28 : (o == 2) ? 5'd30 : 5'd31;
            mem1_pkg::LWR: b.rstrb = (o == 0) ? 5'd31 : (o == 1) ? 5'd23 : (o == 2) ? 5'd19 : 5'd17;
            default:       b.rstrb = 5'd31;
        endcase
        if (op inside {mem1_pkg::LB, mem1_pkg::LBU, mem1_pkg::SB})
            b.size = 2'd0;
        else if (op inside {mem1_pkg::LH, mem1_pkg::LHU, mem1_pkg::SH})
            b.size = 2'd1;
        else
            b.size = 2'd2;
        return b;
    endfunction

    function automatic beat_t sample_beat();
        return {out_exc, 5'(out_exc_code), out_refill, out_badvaddr, out_uncached, out_paddr,
                out_write, out_wstrb, out_wdata, out_rstrb, out_size, out_sc_ok};
    endfunction

    task automatic check_field(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (exp == got) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_beat(beat_t e, beat_t a);
        logic [31:0] mask;
        mask = {{8{e.wstrb[3]}}, {8{e.wstrb[2]}}, {8{e.wstrb[1]}}, {8{e.wstrb[0]}}};
        check_field("out_exc", 32'(e.exc), 32'(a.exc));
        check_field("out_exc_code", 32'(e.code), 32'(a.code));
        check_field("out_refill", 32'(e.refill), 32'(a.refill));
        if (e.exc) begin
            check_field("out_badvaddr", e.badvaddr, a.badvaddr);
        end else begin  // address only meaningful without a fault
            check_field("out_paddr", e.paddr, a.paddr);
            check_field("out_uncached", 32'(e.uncached), 32'(a.uncached));
        end
        check_field("out_write", 32'(e.write), 32'(a.write));
        check_field("out_wstrb", 32'(e.wstrb), 32'(a.wstrb));
        check_field("out_wdata", e.wdata & mask, a.wdata & mask);
        check_field("out_rstrb", 32'(e.rstrb), 32'(a.rstrb));
        check_field("out_size", 32'(e.size), 32'(a.size));
        check_field("out_sc_ok", 32'(e.sc_ok), 32'(a.sc_ok));
    endtask

    always @(negedge clk) begin
        if (!rst)  // a stalled result blocks new requests
            check_field("in_ready", (out_valid && !out_ready) ? 32'd0 : 32'd1,
                        32'(in_ready));
        if (!rst && out_valid) begin
            act = sample_beat();
            if (held_valid) begin
                checks++;
                assert (act == held) else begin
                    $display("%0t: result beat changed while out_ready was low", $time);
                    errors++;
                end
            end
            if (out_ready) begin
                held_valid = 1'b0;
                if (exp_q.size() == 0) begin
                    $display("%0t: result beat appeared with no request pending", $time);
                    errors++;
                end else begin
                    compare_beat(exp_q.pop_front(), act);
                end
            end else begin
                held       = act;
                held_valid = 1'b1;
            end
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = bp_mode ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    end

    task automatic stall_abort(string what);
        $display("timeout: %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic send_req(mem1_pkg::mem_op_t op, logic [31:0] va, logic [31:0] wd);
        beat_t b;
        int    waited;
        waited   = 0;
        in_valid = 1'b1;
        in_op    = op;
        in_vaddr = va;
        in_wdata = wd;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > 100)
                stall_abort("request was not accepted within 100 cycles");
            @(negedge clk);
        end
        b = expect_beat(op, va, wd);
        exp_q.push_back(b);
        if (b.exc || op == mem1_pkg::SC)
            m_link = 1'b0;
        else if (op == mem1_pkg::LL) begin
            m_link      = 1'b1;
            m_link_addr = va;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic write_tlb(int idx, logic [19:0] vpn, logic [19:0] pfn, logic [2:0] c,
                             logic v, logic d);
        cfg_tlb_we = 1'b1;
        cfg_index  = 2'(idx);
        cfg_vpn    = vpn;
        cfg_pfn    = pfn;
        cfg_c      = c;
        cfg_v      = v;
        cfg_d      = d;
        @(posedge clk);
        #1;
        cfg_tlb_we     = 1'b0;
        m_present[idx] = 1'b1;
        m_vpn[idx]     = vpn;
        m_pfn[idx]     = pfn;
        m_c[idx]       = c;
        m_v[idx]       = v;
        m_d[idx]       = d;
    endtask

    task automatic write_k0(logic [2:0] k0);
        cfg_k0_we = 1'b1;
        cfg_k0    = k0;
        @(posedge clk);
        #1;
        cfg_k0_we = 1'b0;
        m_k0      = k0;
    endtask

    task automatic start_test();
        test_no++;
        checks_at = checks;
        errors_at = errors;
    endtask

    task automatic finish_test(string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 500)
                stall_abort("results did not drain within 500 cycles");
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        $display("test %0d %s: %0d checks, %0d errors", test_no, name,
                 checks - checks_at, errors - errors_at);
    endtask

    task automatic random_reqs(int n);
        logic [31:0] va;
        for (int i = 0; i < n; i++) begin
            case ($urandom_range(0, 2))
                0:       va = 32'h8000_0000 | ($urandom & 32'h01ff_ffff);
                1:       va = 32'ha000_0000 | ($urandom & 32'h01ff_ffff);
                default: va = 32'h0040_0000 | ($urandom & 32'h0000_0fff);  // entry 0 page
            endcase
            send_req(mem1_pkg::mem_op_t'(4'($urandom_range(0, 13))), va, $urandom);
        end
    endtask

    initial begin
        void'($urandom(39361));
        rst = 1'b1;
        in_valid = 1'b0;
        in_op = mem1_pkg::LW;
        in_vaddr = 32'd0;
        in_wdata = 32'd0;
        cfg_tlb_we = 1'b0;
        cfg_index = 2'd0;
        cfg_vpn = 20'd0;
        cfg_pfn = 20'd0;
        cfg_c = 3'd0;
        cfg_v = 1'b0;
        cfg_d = 1'b0;
        cfg_k0_we = 1'b0;
        cfg_k0 = 3'd0;
        bp_mode = 1'b0;
        held_valid = 1'b0;
        checks = 0;
        errors = 0;
        test_no = 0;
        for (int i = 0; i < TLB_N; i++) begin
            m_present[i] = 1'b0;
            m_vpn[i] = '0;
            m_pfn[i] = '0;
            m_c[i] = '0;
            m_v[i] = 1'b0;
            m_d[i] = 1'b0;
        end
        m_k0 = 3'd2;
        m_link = 1'b0;
        m_link_addr = 32'd0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        start_test();
        send_req(mem1_pkg::LW, 32'h8000_1234, 32'd0);
        send_req(mem1_pkg::SW, 32'ha000_0010, 32'h1122_3344);
        write_k0(3'd3);
        send_req(mem1_pkg::LW, 32'h8000_1234, 32'd0);
        send_req(mem1_pkg::SB, 32'ha7ff_fff1, 32'h0000_00a5);
        finish_test("unmapped segments");

        start_test();
        write_tlb(0, 20'h00400, 20'h12345, 3'd3, 1'b1, 1'b1);
        write_tlb(1, 20'h00401, 20'h0abcd, 3'd2, 1'b1, 1'b0);
        write_tlb(2, 20'h00402, 20'h55555, 3'd3, 1'b0, 1'b1);
        write_tlb(3, 20'hc0000, 20'h00777, 3'd3, 1'b1, 1'b1);
        send_req(mem1_pkg::LW, 32'h0040_0010, 32'd0);
        send_req(mem1_pkg::SW, 32'h0040_0020, 32'hdead_beef);
        send_req(mem1_pkg::LW, 32'h0040_1000, 32'd0);
        send_req(mem1_pkg::SW, 32'h0040_1004, 32'h0bad_cafe);
        send_req(mem1_pkg::LW, 32'h0040_2000, 32'd0);
        send_req(mem1_pkg::SB, 32'h0040_2003, 32'h0000_0077);
        send_req(mem1_pkg::LW, 32'h0050_0000, 32'd0);
        send_req(mem1_pkg::SH, 32'h0050_0002, 32'h0000_1234);
        send_req(mem1_pkg::LW, 32'hc000_0008, 32'd0);
        finish_test("mapped accesses");

        start_test();
        send_req(mem1_pkg::LW, 32'h8000_0001, 32'd0);
        send_req(mem1_pkg::SW, 32'h8000_0002, 32'h0102_0304);
        send_req(mem1_pkg::LH, 32'h0050_0001, 32'd0);
        send_req(mem1_pkg::SH, 32'h0040_1003, 32'h0000_5678);
        send_req(mem1_pkg::LHU, 32'h8000_0003, 32'd0);
        finish_test("address errors");

        start_test();
        random_reqs(200);
        finish_test("random formats");

        start_test();
        send_req(mem1_pkg::LL, 32'h8000_0100, 32'd0);
        send_req(mem1_pkg::SC, 32'h8000_0100, 32'h1111_2222);
        send_req(mem1_pkg::SC, 32'h8000_0100, 32'h3333_4444);
        send_req(mem1_pkg::LL, 32'h8000_0200, 32'd0);
        send_req(mem1_pkg::SC, 32'h8000_0204, 32'h5555_6666);
        send_req(mem1_pkg::LL, 32'h8000_0300, 32'd0);
        send_req(mem1_pkg::LW, 32'h8000_0301, 32'd0);  // adel drops the link
        send_req(mem1_pkg::SC, 32'h8000_0300, 32'h7777_8888);
        finish_test("ll/sc link");

        start_test();
        bp_mode = 1'b1;
        random_reqs(300);
        finish_test("back-pressure");
        bp_mode = 1'b0;

        $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem1_prep.f ====
mem1_pkg.sv
mem1_ifs.sv
tlb_config_regs.sv
addr_translate.sv
access_format.sv
ll_sc_link.sv
mem1_issue.sv
mem1_prep_top.sv
tb_mem1_prep.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_mem1_prep -f mem1_prep.f \
    -o sim_mem1_prep > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_mem1_prep > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "^TEST OK$" sim.log && exit 0 || exit 1
